//--- hw/rv_pkg.sv
// rv64 core shared definitions
package rv_pkg;

  localparam int xlen = 64;  // data path width

  // one code per supported instruction
  typedef enum logic [4:0] {
    op_illegal,
    op_ebreak,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_bge,
    op_bltu,
    op_bgeu,
    op_ld,
    op_sd,
    op_addi,
    op_sltiu,
    op_xori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    op_add,
    op_sub,
    op_sltu,
    op_or,
    op_and,
    op_addw
  } op_e;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_32  = 7'b0111011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [31:0] inst_ebreak = 32'h00100073;  // full ebreak word

endpackage

//--- hw/decode_if.sv
// decoded instruction bundle
`timescale 1ns/10ps

interface decode_if import rv_pkg::*; ();

  op_e             op;        // instruction class
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [5:0]      shamt;     // rv64 shift amount
  logic [xlen-1:0] imm;       // sign extended immediate
  logic            uses_rs2;  // second operand comes from rs2

  modport producer (
    output op, rd, rs1, rs2, shamt, imm, uses_rs2
  );

  modport consumer (
    input op, rd, rs1, rs2, shamt, imm, uses_rs2
  );

  modport regs (
    input rs1, rs2
  );

endinterface

//--- hw/mux_key.sv
// key match lookup table
`timescale 1ns/10ps

module mux_key #(
  parameter int nr_key   = 2,
  parameter int key_len  = 1,
  parameter int data_len = 1
) (
  input  logic [key_len-1:0]                    key,
  input  logic [data_len-1:0]                   default_out,
  input  logic [nr_key*(key_len+data_len)-1:0]  lut,
  output logic [data_len-1:0]                   out
);

  localparam int pair_len = key_len + data_len;  // one key/data entry

  // entries never overlap, so at most one match drives out
  always_comb begin
    out = default_out;
    for (int i = 0; i < nr_key; i++) begin
      if (lut[i*pair_len+data_len +: key_len] == key) begin
        out = lut[i*pair_len +: data_len];
      end
    end
  end

endmodule

//--- hw/inst_decode.sv
// rv64 instruction decoder
`timescale 1ns/10ps

module inst_decode import rv_pkg::*; (
  input logic [31:0]  inst,
  decode_if.producer  dec
);

  localparam int op_len = $bits(op_e);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [xlen-1:0]   imm_i;
  logic [xlen-1:0]   imm_u;
  logic [xlen-1:0]   imm_j;
  logic [xlen-1:0]   imm_b;
  logic [xlen-1:0]   imm_s;
  logic [op_len-1:0] op_major;   // lui, auipc, jal
  logic [op_len-1:0] op_funct7;  // r-type and shift immediates
  logic [op_len-1:0] op_funct3;  // final table output

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // bit 25 is shamt[5] on op-imm, so it takes no part in the key there
  assign funct7 = {inst[31:26], inst[25] & (opcode != opc_op_imm)};

  assign dec.rd    = inst[11:7];
  assign dec.rs1   = inst[19:15];
  assign dec.rs2   = inst[24:20];
  assign dec.shamt = inst[25:20];

  // sign extended immediate formats
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    case (opcode)
      opc_lui, opc_auipc:                     dec.imm = imm_u;
      opc_jal:                                dec.imm = imm_j;
      opc_branch:                             dec.imm = imm_b;
      opc_store:                              dec.imm = imm_s;
      opc_jalr, opc_load, opc_op_imm, opc_system: dec.imm = imm_i;
      default:                                dec.imm = '0;
    endcase
  end

  assign dec.uses_rs2 = (opcode == opc_op) || (opcode == opc_op_32) ||
                        (opcode == opc_branch) || (opcode == opc_store);

  mux_key #(.nr_key(3), .key_len(7), .data_len(op_len)) u_key_major (
    .key         (opcode),
    .default_out (op_illegal),
    .lut         ({
      opc_lui,   op_lui,
      opc_auipc, op_auipc,
      opc_jal,   op_jal
    }),
    .out         (op_major)
  );

  mux_key #(.nr_key(9), .key_len(17), .data_len(op_len)) u_key_funct7 (
    .key         ({funct7, funct3, opcode}),
    .default_out (op_major),  // falls through to the major table
    .lut         ({
      7'b0000000, 3'b000, opc_op,     op_add,
      7'b0100000, 3'b000, opc_op,     op_sub,
      7'b0000000, 3'b011, opc_op,     op_sltu,
      7'b0000000, 3'b110, opc_op,     op_or,
      7'b0000000, 3'b111, opc_op,     op_and,
      7'b0000000, 3'b000, opc_op_32,  op_addw,
      7'b0000000, 3'b001, opc_op_imm, op_slli,
      7'b0000000, 3'b101, opc_op_imm, op_srli,
      7'b0100000, 3'b101, opc_op_imm, op_srai
    }),
    .out         (op_funct7)
  );

  mux_key #(.nr_key(12), .key_len(10), .data_len(op_len)) u_key_funct3 (
    .key         ({funct3, opcode}),
    .default_out (op_funct7),
    .lut         ({
      3'b000, opc_jalr,   op_jalr,
      3'b000, opc_branch, op_beq,
      3'b001, opc_branch, op_bne,
      3'b101, opc_branch, op_bge,
      3'b110, opc_branch, op_bltu,
      3'b111, opc_branch, op_bgeu,
      3'b011, opc_load,   op_ld,
      3'b011, opc_store,  op_sd,
      3'b000, opc_op_imm, op_addi,
      3'b011, opc_op_imm, op_sltiu,
      3'b100, opc_op_imm, op_xori,
      3'b111, opc_op_imm, op_andi
    }),
    .out         (op_funct3)
  );

  // ebreak is a whole word match
  assign dec.op = (inst == inst_ebreak) ? op_ebreak : op_e'(op_funct3);

endmodule

//--- hw/reg_file.sv
// integer register file
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  decode_if.regs          rd_if,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  logic            we,
  input  logic [4:0]      wr_rd,
  input  logic [xlen-1:0] wr_data
);

  logic [xlen-1:0] mem [32];  // x0..x31

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        mem[i] <= '0;
      end
    end else if (we && (wr_rd != 5'd0)) begin
      mem[wr_rd] <= wr_data;  // x0 never written
    end
  end

  // x0 reads as zero
  assign rs1_data = (rd_if.rs1 == 5'd0) ? '0 : mem[rd_if.rs1];
  assign rs2_data = (rd_if.rs2 == 5'd0) ? '0 : mem[rd_if.rs2];

endmodule

//--- hw/alu_exec.sv
// execute and branch unit
`timescale 1ns/10ps

module alu_exec import rv_pkg::*; (
  decode_if.consumer      dec,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] load_data,
  output logic [xlen-1:0] result,
  output logic            rd_we,
  output logic [xlen-1:0] next_pc,
  output logic [xlen-1:0] mem_addr,
  output logic            mem_store,
  output logic            stop,
  output logic            bad
);

  logic [xlen-1:0] opb;       // rs2 or immediate
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [xlen-1:0] ea;        // rs1 + imm
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_imm;
  logic            taken;
  logic            writes;    // instruction has a destination

  assign opb      = dec.uses_rs2 ? rs2_data : dec.imm;
  assign sum      = rs1_data + opb;
  assign diff     = rs1_data - rs2_data;
  assign ea       = rs1_data + dec.imm;
  assign pc_plus4 = pc + xlen'(4);
  assign pc_imm   = pc + dec.imm;

  always_comb begin
    case (dec.op)
      op_beq:  taken = (rs1_data == rs2_data);
      op_bne:  taken = (rs1_data != rs2_data);
      op_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      op_bltu: taken = (rs1_data < rs2_data);
      op_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    result = '0;
    writes = 1'b1;
    case (dec.op)
      op_lui:            result = dec.imm;
      op_auipc:          result = pc_imm;
      op_jal, op_jalr:   result = pc_plus4;  // link value
      op_ld:             result = load_data;
      op_addi, op_add:   result = sum;
      op_sub:            result = diff;
      op_sltiu, op_sltu: result = {{(xlen-1){1'b0}}, (rs1_data < opb)};
      op_xori:           result = rs1_data ^ opb;
      op_andi, op_and:   result = rs1_data & opb;
      op_or:             result = rs1_data | opb;
      op_slli:           result = rs1_data << dec.shamt;
      op_srli:           result = rs1_data >> dec.shamt;
      op_srai:           result = xlen'($signed(rs1_data) >>> dec.shamt);
      op_addw:           result = {{(xlen-32){sum[31]}}, sum[31:0]};  // wrap then extend
      default:           writes = 1'b0;
    endcase
  end

  assign stop = (dec.op == op_ebreak) || (dec.op == op_illegal);
  assign bad  = (dec.op == op_illegal);

  always_comb begin
    if (stop) begin
      next_pc = pc;  // hold on the halting word
    end else if ((dec.op == op_jal) || taken) begin
      next_pc = pc_imm;
    end else if (dec.op == op_jalr) begin
      next_pc = ea & ~xlen'(1);
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign mem_addr  = ea;
  assign mem_store = (dec.op == op_sd);
  assign rd_we     = writes && (dec.rd != 5'd0);

endmodule

//--- hw/core_top.sv
// single cycle rv64 core
`timescale 1ns/10ps

module core_top import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  output logic [xlen-1:0] imem_addr,
  input  logic [31:0]     imem_data,
  output logic [xlen-1:0] dmem_addr,
  input  logic [xlen-1:0] dmem_rdata,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_we,
  output logic            wb_en,
  output logic [4:0]      wb_rd,
  output logic [xlen-1:0] wb_data,
  output logic [xlen-1:0] retire_pc,
  output logic            halted,
  output logic            illegal
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic            rd_we;
  logic            mem_store;
  logic            stop;
  logic            bad;
  logic            run;  // core may commit this cycle

  decode_if u_dec_if ();

  inst_decode u_inst_decode (
    .inst (imem_data),
    .dec  (u_dec_if.producer)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rd_if    (u_dec_if.regs),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_en),
    .wr_rd    (wb_rd),
    .wr_data  (wb_data)
  );

  alu_exec u_alu_exec (
    .dec       (u_dec_if.consumer),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .load_data (dmem_rdata),
    .result    (alu_result),
    .rd_we     (rd_we),
    .next_pc   (next_pc),
    .mem_addr  (dmem_addr),
    .mem_store (mem_store),
    .stop      (stop),
    .bad       (bad)
  );

  assign run        = !rst && !halted;
  assign imem_addr  = pc;
  assign retire_pc  = pc;
  assign wb_en      = rd_we && run;
  assign wb_rd      = u_dec_if.rd;
  assign wb_data    = alu_result;
  assign dmem_we    = mem_store && run;
  assign dmem_wdata = rs2_data;  // sd stores rs2

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= reset_pc;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (!halted) begin
      pc <= next_pc;
      if (stop) begin
        halted  <= 1'b1;  // sticky until rst
        illegal <= bad;
      end
    end
  end

endmodule

//--- bench/core_sva.sv
// core port protocol assertions
`timescale 1ns/10ps

module core_sva (
  input logic        clk,
  input logic        rst,
  input logic [63:0] imem_addr,
  input logic        wb_en,
  input logic [4:0]  wb_rd,
  input logic        dmem_we,
  input logic        halted,
  input logic        illegal
);

  a_wb_rd_nonzero: assert property (@(posedge clk) wb_en |-> (wb_rd != 5'd0))
    else $error("write back enabled for x0");

  a_halt_pc_hold: assert property (@(posedge clk) (halted && !rst) |=> $stable(imem_addr))
    else $error("pc moved while halted");

  a_halt_quiet: assert property (@(posedge clk) halted |-> (!wb_en && !dmem_we))
    else $error("write or store enabled while halted");

  a_halt_sticky: assert property (@(posedge clk) (halted && !rst) |=> halted)
    else $error("halted dropped without reset");

  a_illegal_halts: assert property (@(posedge clk) illegal |-> halted)
    else $error("illegal set without halted");

endmodule

bind core_top core_sva u_core_sva (.*);

//--- bench/tb_core.sv
// rv64 core testbench
`timescale 1ns/10ps

module tb_core;
  import rv_pkg::*;

  // resets, reset hold, program words, loop iterations, margin
  localparam int cycle_limit = 6 * 12 + 70 + 40 + 200;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [63:0] imem_addr, dmem_addr, dmem_rdata, dmem_wdata, wb_data, retire_pc;
  logic [31:0] imem_data;
  logic        dmem_we, wb_en, halted, illegal;
  logic [4:0]  wb_rd;
  logic [31:0] imem [256];
  logic [63:0] dmem [64];
  logic [63:0] mregs [32];  // shadow register file
  logic [63:0] mpc, e_data, e_addr, e_wdata, e_npc;
  logic        mhalt, mill, e_we, e_st, e_ld, e_stop, e_bad;
  logic [4:0]  e_rd;
  int          seed = 32'h15cd;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycles = 0;
  int          np;

  always #50 clk = ~clk;

  core_top #(.reset_pc(64'h1000)) u_core_top (.*);

  // program window at 0x1000, anything else reads as zero
  assign imem_data  = (imem_addr[63:10] == 54'h4) ? imem[imem_addr[9:2]] : 32'h0;
  assign dmem_rdata = dmem[dmem_addr[8:3]];

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[8:3]] <= dmem_wdata;
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, core never finished", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // model decode and compare while outputs are settled
  always @(negedge clk) begin
    logic [31:0] w;
    logic [63:0] a, b, ii, is, ib, iu, ij, s;
    w  = (mpc[63:10] == 54'h4) ? imem[mpc[9:2]] : 32'h0;
    a  = mregs[w[19:15]];
    b  = mregs[w[24:20]];
    ii = {{52{w[31]}}, w[31:20]};
    is = {{52{w[31]}}, w[31:25], w[11:7]};
    ib = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    iu = {{32{w[31]}}, w[31:12], 12'h0};
    ij = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e_rd = w[11:7];
    {e_we, e_st, e_ld, e_stop, e_bad} = 5'b10000;
    e_data = 64'h0;
    e_addr = a + ii;
    e_wdata = b;
    e_npc = mpc + 64'd4;
    case (w[6:0])
      opc_lui:   e_data = iu;
      opc_auipc: e_data = mpc + iu;
      opc_jal: begin
        e_data = mpc + 64'd4;
        e_npc = mpc + ij;
      end
      opc_jalr: begin
        e_data = mpc + 64'd4;
        e_npc = (a + ii) & ~64'd1;
        e_bad = (w[14:12] != 3'b000);
      end
      opc_branch: begin
        e_we = 1'b0;
        case (w[14:12])
          3'b000: if (a == b) e_npc = mpc + ib;
          3'b001: if (a != b) e_npc = mpc + ib;
          3'b101: if ($signed(a) >= $signed(b)) e_npc = mpc + ib;
          3'b110: if (a < b) e_npc = mpc + ib;
          3'b111: if (a >= b) e_npc = mpc + ib;
          default: e_bad = 1'b1;
        endcase
      end
      opc_load: begin
        e_ld = 1'b1;
        e_data = dmem[e_addr[8:3]];
        e_bad = (w[14:12] != 3'b011);
      end
      opc_store: begin
        e_we = 1'b0;
        e_st = 1'b1;
        e_addr = a + is;
        e_bad = (w[14:12] != 3'b011);
      end
      opc_op_imm: begin
        case (w[14:12])
          3'b000: e_data = a + ii;
          3'b011: e_data = (a < ii) ? 64'd1 : 64'd0;
          3'b100: e_data = a ^ ii;
          3'b111: e_data = a & ii;
          3'b001: begin
            e_data = a << w[25:20];
            e_bad = (w[31:26] != 6'h00);
          end
          3'b101: begin
            e_data = (w[30]) ? 64'($signed(a) >>> w[25:20]) : a >> w[25:20];
            e_bad = ({w[31], w[29:26]} != 5'h00);
          end
          default: e_bad = 1'b1;
        endcase
      end
      opc_op: begin
        case ({w[31:25], w[14:12]})
          10'b0000000_000: e_data = a + b;
          10'b0100000_000: e_data = a - b;
          10'b0000000_011: e_data = (a < b) ? 64'd1 : 64'd0;
          10'b0000000_110: e_data = a | b;
          10'b0000000_111: e_data = a & b;
          default: e_bad = 1'b1;
        endcase
      end
      opc_op_32: begin
        s = a + b;
        e_data = {{32{s[31]}}, s[31:0]};  // 32 bit wrap, then extend
        e_bad = ({w[31:25], w[14:12]} != 10'h0);
      end
      default: e_bad = (w != inst_ebreak);
    endcase
    e_stop = e_bad || (w == inst_ebreak);
    if (e_stop) e_st = 1'b0;
    e_we = e_we && !e_stop && (e_rd != 5'd0);
    if (!rst) begin
      check("imem_addr", imem_addr, mpc);
      check("retire_pc", retire_pc, mpc);
      check("halted", 64'(halted), 64'(mhalt));
      check("illegal", 64'(illegal), 64'(mill));
      check("wb_en", 64'(wb_en), 64'(e_we && !mhalt));
      check("dmem_we", 64'(dmem_we), 64'(e_st && !mhalt));
      if (e_we && !mhalt) begin
        check("wb_rd", 64'(wb_rd), 64'(e_rd));
        check("wb_data", wb_data, e_data);
      end
      if ((e_st || e_ld) && !mhalt) check("dmem_addr", dmem_addr, e_addr);
      if (e_st && !mhalt) check("dmem_wdata", dmem_wdata, e_wdata);
    end
  end

  // model commit in lockstep with the core
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) mregs[i] = 64'h0;
      mpc = 64'h1000;
      mhalt = 1'b0;
      mill = 1'b0;
    end else if (!mhalt) begin
      if (e_we) mregs[e_rd] = e_data;
      if (e_stop) begin
        mhalt = 1'b1;
        mill = e_bad;
      end else begin
        mpc = e_npc;
      end
    end
  end

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] opc, logic [6:0] f7, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[np] = w;
    np++;
  endtask

  task automatic new_program();
    for (int i = 0; i < 256; i++) imem[i] = 32'h0;
    for (int i = 0; i < 64; i++) dmem[i] <= {32'($random(seed)), 32'($random(seed))};
    np = 0;
  endtask

  task automatic run_test(input string name);
    int e0;
    e0 = errors;
    tests++;
    @(posedge clk);
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (!halted) @(posedge clk);
    repeat (3) @(posedge clk);  // pc must hold here
    if (errors == e0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d mismatches", tests, name, errors - e0);
  endtask

  initial begin
    new_program();
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'($random(seed))));
    emit(enc_i(opc_op_imm, 3'b011, 5'd2, 5'd1, 12'($random(seed))));
    emit(enc_i(opc_op_imm, 3'b100, 5'd3, 5'd1, 12'($random(seed))));
    emit(enc_i(opc_op_imm, 3'b111, 5'd4, 5'd1, 12'($random(seed))));
    emit({20'($random(seed)), 5'd5, opc_lui});
    emit({20'($random(seed)) | 20'h80000, 5'd6, opc_auipc});  // negative offset
    emit(enc_i(opc_load, 3'b011, 5'd7, 5'd0, 12'd8));
    emit(enc_i(opc_op_imm, 3'b000, 5'd8, 5'd7, 12'hffb));
    emit(enc_i(opc_op_imm, 3'b011, 5'd9, 5'd7, 12'hfff));
    emit(inst_ebreak);
    run_test("immediates");

    new_program();
    emit(enc_i(opc_load, 3'b011, 5'd1, 5'd0, 12'd0));
    emit(enc_i(opc_load, 3'b011, 5'd2, 5'd0, 12'd8));
    emit(enc_r(opc_op, 7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(enc_r(opc_op, 7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(enc_r(opc_op, 7'h00, 3'b011, 5'd5, 5'd1, 5'd2));
    emit(enc_r(opc_op, 7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    emit(enc_r(opc_op, 7'h00, 3'b111, 5'd7, 5'd1, 5'd2));
    emit(enc_r(opc_op_32, 7'h00, 3'b000, 5'd8, 5'd1, 5'd2));
    emit(enc_i(opc_op_imm, 3'b001, 5'd9, 5'd1, {6'h00, 6'($random(seed))}));
    emit(enc_i(opc_op_imm, 3'b101, 5'd10, 5'd1, {6'h00, 6'($random(seed))}));
    emit(enc_i(opc_op_imm, 3'b101, 5'd11, 5'd1, {6'h10, 6'd63}));
    emit(enc_i(opc_op_imm, 3'b101, 5'd12, 5'd2, {6'h10, 6'($random(seed))}));
    emit(enc_r(opc_op, 7'h00, 3'b000, 5'd0, 5'd1, 5'd2));  // x0 target
    emit(inst_ebreak);
    run_test("register ops");

    new_program();
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd5));
    emit(enc_i(opc_op_imm, 3'b000, 5'd2, 5'd2, 12'd1));
    emit(enc_b(3'b001, 5'd2, 5'd1, 13'h1ffc));  // bne back
    emit(enc_i(opc_op_imm, 3'b000, 5'd3, 5'd3, 12'd1));
    emit(enc_b(3'b110, 5'd3, 5'd1, 13'h1ffc));  // bltu back
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
    emit(enc_i(opc_op_imm, 3'b000, 5'd10, 5'd0, 12'd1));
    emit(enc_b(3'b000, 5'd0, 5'd1, 13'd8));  // beq not taken
    emit(enc_b(3'b101, 5'd0, 5'd1, 13'd8));
    emit(enc_i(opc_op_imm, 3'b000, 5'd11, 5'd0, 12'd2));
    emit(enc_i(opc_op_imm, 3'b000, 5'd18, 5'd0, 12'hfff));
    emit(enc_b(3'b101, 5'd0, 5'd18, 13'd8));  // signed compare, taken
    emit(enc_i(opc_op_imm, 3'b000, 5'd19, 5'd0, 12'd6));
    emit(enc_b(3'b111, 5'd1, 5'd0, 13'd8));
    emit(enc_i(opc_op_imm, 3'b000, 5'd12, 5'd0, 12'd3));
    emit(enc_b(3'b111, 5'd0, 5'd1, 13'd8));
    emit(enc_j(5'd13, 21'd8));
    emit(enc_i(opc_op_imm, 3'b000, 5'd14, 5'd0, 12'd4));
    emit({20'h0, 5'd16, opc_auipc});
    emit(enc_i(opc_jalr, 3'b000, 5'd15, 5'd16, 12'd13));  // odd target
    emit(enc_i(opc_op_imm, 3'b000, 5'd17, 5'd0, 12'd5));
    emit(inst_ebreak);
    run_test("control flow");

    new_program();
    emit(enc_i(opc_load, 3'b011, 5'd1, 5'd0, 12'd0));
    emit(enc_i(opc_load, 3'b011, 5'd2, 5'd0, 12'd8));
    emit(enc_s(5'd0, 5'd1, 12'd64));
    emit(enc_s(5'd0, 5'd2, 12'd72));
    emit(enc_i(opc_load, 3'b011, 5'd3, 5'd0, 12'd64));
    emit(enc_i(opc_load, 3'b011, 5'd4, 5'd0, 12'd72));
    emit(enc_i(opc_op_imm, 3'b000, 5'd6, 5'd0, 12'd128));
    emit(enc_s(5'd6, 5'd2, 12'hff8));
    emit(enc_i(opc_load, 3'b011, 5'd7, 5'd6, 12'hff8));
    emit(enc_i(opc_load, 3'b011, 5'd8, 5'd0, 12'd16));
    emit(inst_ebreak);
    run_test("memory");

    new_program();
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd7));
    emit(inst_ebreak);
    emit(enc_i(opc_op_imm, 3'b000, 5'd2, 5'd0, 12'd9));
    run_test("ebreak halt");

    new_program();
    emit(enc_i(opc_op_imm, 3'b000, 5'd1, 5'd0, 12'd3));
    emit(32'hffffffff);
    emit(enc_i(opc_op_imm, 3'b000, 5'd2, 5'd0, 12'd4));
    run_test("illegal halt");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/rv_pkg.sv
hw/decode_if.sv
hw/mux_key.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/core_top.sv
bench/core_sva.sv
bench/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with verilator

log=sim.log

verilator --binary --assert -f flist.f --top-module tb_core -o sim_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$log"; then
  exit 1
fi
exit 0
